// File: build.f
hdl/fetch_pkg.sv
hdl/wait_timer.sv
hdl/branch_predictor.sv
hdl/next_pc_unit.sv
hdl/fetch_ctrl.sv
hdl/fetch_top.sv
sim/tb_fetch.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the fetch testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_fetch -f build.f -o tb_fetch

./obj_dir/tb_fetch | tee sim.log

# Verdict comes from the log
if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi

// File: sim/tb_fetch.sv
`timescale 1ns/1ns

module tb_fetch;

    logic CLK;
    logic RST;
    logic wb_cyc_o;
    logic wb_stb_o;
    logic [fetch_pkg::XLEN-1:0] wb_adr_o;
    logic wb_we_o;
    logic [fetch_pkg::XLEN-1:0] wb_dat_i;
    logic wb_ack_i;
    logic stall_i;
    logic jr_i;
    logic [fetch_pkg::XLEN-1:0] address_jr_i;
    logic prewrong_i;
    logic [fetch_pkg::XLEN-1:0] instr_o;
    logic [fetch_pkg::XLEN-1:0] pc_o;
    logic [fetch_pkg::XLEN-1:0] pcplus1_o;
    logic pred_taken_o;
    logic valid_o;
    logic bus_err_o;

    // Memory image, dead address and wait-state state
    fetch_pkg::instr_word_u mem [0:255];
    logic [15:0] dead_addr;
    logic dead_en;
    int wait_left;
    // Reference model
    logic [fetch_pkg::PRED_DEPTH-1:0] pred_tbl;
    logic [15:0] exp_pc;
    // Bookkeeping
    int errors;
    int checks;
    int tests;
    int failed_tests;
    int test_err_start;
    bit timed_out;
    string cur_test;

    fetch_top uut (.*);

    always #2 CLK = ~CLK;

    //////////////////////////////////////////////////
    // Wishbone slave model
    //////////////////////////////////////////////////

    // 0 to 3 wait states per request
    // Dead address never acked
    always begin
        @(posedge CLK);
        #1;
        if (wb_ack_i) begin
            wb_ack_i = 1'b0;
        end else if (wb_cyc_o && wb_stb_o && !(dead_en && wb_adr_o == dead_addr)) begin
            if (wait_left < 0) begin
                wait_left = $urandom_range(0, 3);
            end
            if (wait_left == 0) begin
                wb_dat_i = mem[wb_adr_o[7:0]];
                wb_ack_i = 1'b1;
                wait_left = -1;
            end else begin
                wait_left = wait_left - 1;
            end
        end else if (!wb_cyc_o) begin
            wait_left = -1;
        end
    end

    //////////////////////////////////////////////////
    // Protocol and hold checks
    //////////////////////////////////////////////////

    function automatic void report_rule(input string msg);
        errors++;
        $display("** Error %s: %s", cur_test, msg);
    endfunction

    assert property (@(posedge CLK) disable iff (!RST) (wb_cyc_o == wb_stb_o) && !wb_we_o)
        else report_rule("cyc and stb differ or a write was driven");
    // Address held until ack unless the cycle is aborted
    assert property (@(posedge CLK) disable iff (!RST) (wb_cyc_o && !wb_ack_i) |=>
        ((wb_cyc_o && $stable(wb_adr_o)) || bus_err_o))
        else report_rule("bus cycle dropped or address moved before ack");
    assert property (@(posedge CLK) disable iff (!RST) (wb_cyc_o && wb_ack_i) |=> !wb_cyc_o)
        else report_rule("cyc still high in the cycle after ack");
    // Issue outputs frozen under back-pressure
    assert property (@(posedge CLK) disable iff (!RST) (valid_o && stall_i) |=>
        (valid_o && $stable(pc_o) && $stable(instr_o) && $stable(pcplus1_o)
         && $stable(pred_taken_o)))
        else report_rule("issue outputs changed while stalled");

    function automatic void compare_word(input string what, input logic [15:0] exp,
                                         input logic [15:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("** Error %s %s: expected %h actual %h", cur_test, what, exp, act);
        end
    endfunction

    function automatic void start_test(input string name);
        cur_test = name;
        test_err_start = errors;
    endfunction

    function automatic void end_test();
        tests++;
        if (errors == test_err_start) begin
            $display("test %s: pass", cur_test);
        end else begin
            failed_tests++;
            $display("test %s: fail with %0d errors", cur_test, errors - test_err_start);
        end
    endfunction

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic wait_valid();
        int n;
        n = 0;
        while (!valid_o && !timed_out) begin
            @(posedge CLK);
            #1;
            n++;
            if (n > 40) begin
                $display("Timeout in %s: no instruction issued after %0d cycles", cur_test, n);
                errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    // Stall_i idles high
    // One word taken per call
    task automatic issue_one(input int stall_n, input bit do_jr, input logic [15:0] jaddr,
                             input bit do_pw);
        fetch_pkg::instr_word_u w;
        logic taken;
        logic [15:0] imm;
        logic [15:0] seq;
        wait_valid();
        if (timed_out) begin
            return;
        end
        repeat (stall_n) begin
            @(posedge CLK);
            #1;
        end
        // Expected decode of the word at the model PC
        w = mem[exp_pc[7:0]];
        if (w.jmp.opcode == fetch_pkg::OPC_JUMP) begin
            taken = 1'b1;
            imm = 16'($signed(w.jmp.imm11));
        end else begin
            taken = (w.br.opcode == fetch_pkg::OPC_BRANCH) && pred_tbl[exp_pc[7:0]];
            imm = 16'($signed(w.br.imm8));
        end
        seq = exp_pc + 16'd1;
        compare_word("pc_o", exp_pc, pc_o);
        compare_word("pcplus1_o", seq, pcplus1_o);
        compare_word("instr_o", w, instr_o);
        compare_word("pred_taken_o", {15'd0, taken}, {15'd0, pred_taken_o});
        stall_i = 1'b0;
        jr_i = do_jr;
        address_jr_i = jaddr;
        prewrong_i = do_pw;
        @(posedge CLK);
        #1;
        stall_i = 1'b1;
        jr_i = 1'b0;
        prewrong_i = 1'b0;
        // Mispredict flips the entry
        // Jr wins the redirect
        if (do_pw) begin
            pred_tbl[exp_pc[7:0]] = !pred_tbl[exp_pc[7:0]];
        end
        if (do_jr) begin
            exp_pc = jaddr;
        end else if (taken ^ do_pw) begin
            exp_pc = seq + imm;
        end else begin
            exp_pc = seq;
        end
        // Next request starts right after acceptance at the new PC
        compare_word("wb_cyc_o", 16'd1, {15'd0, wb_cyc_o});
        compare_word("wb_adr_o", exp_pc, wb_adr_o);
    endtask

    // Cycles that cyc stays high
    // Both waits bounded
    task automatic measure_cyc(output int len);
        int n;
        len = 0;
        n = 0;
        while (!wb_cyc_o && n < 10) begin
            @(posedge CLK);
            #1;
            n++;
        end
        while (wb_cyc_o && len < 40) begin
            @(posedge CLK);
            #1;
            len++;
        end
        if (n >= 10 || len >= 40) begin
            $display("Timeout in %s: bus cycle never started or never ended", cur_test);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int i;
        int len;
        void'($urandom(32'h68e6ac03));
        CLK = 1'b0;
        RST = 1'b0;
        wb_dat_i = '0;
        wb_ack_i = 1'b0;
        stall_i = 1'b1;
        jr_i = 1'b0;
        address_jr_i = '0;
        prewrong_i = 1'b0;
        wait_left = -1;
        dead_en = 1'b0;
        dead_addr = 16'h7777;
        exp_pc = fetch_pkg::RESET_PC;
        pred_tbl = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        failed_tests = 0;
        timed_out = 1'b0;
        cur_test = "reset";
        // Plain ALU-style words with opcode 10101 everywhere
        for (i = 0; i < 256; i++) begin
            mem[8'(i)] = {5'b10101, 3'(i >> 5), 8'(i) ^ 8'h3c};
        end
        mem[4] = {fetch_pkg::OPC_JUMP, 11'd20};
        mem[25] = {fetch_pkg::OPC_JUMP, 11'h7f1};
        mem[12] = {fetch_pkg::OPC_BRANCH, 3'b101, 8'd8};
        mem[21] = {fetch_pkg::OPC_JUMP, 11'h7f6};
        repeat (2) begin
            @(posedge CLK);
            #1;
        end
        RST = 1'b1;

        start_test("sequential");
        repeat (4) issue_one(0, 1'b0, 16'd0, 1'b0);
        end_test();

        // 4 jumps forward to 25 and 25 back to 11
        start_test("jump");
        repeat (3) issue_one(0, 1'b0, 16'd0, 1'b0);
        end_test();

        // Branch at 12 trained and later reached again at 0x10c
        start_test("branch_predict");
        issue_one(0, 1'b0, 16'd0, 1'b1);
        issue_one(0, 1'b0, 16'd0, 1'b0);
        issue_one(0, 1'b0, 16'd0, 1'b1);
        issue_one(0, 1'b1, 16'h010c, 1'b0);
        issue_one(0, 1'b0, 16'd0, 1'b1);
        issue_one(0, 1'b0, 16'd0, 1'b0);
        issue_one(0, 1'b1, 16'd12, 1'b0);
        issue_one(0, 1'b0, 16'd0, 1'b0);
        end_test();

        start_test("register_jump");
        issue_one(0, 1'b1, 16'($urandom), 1'b0);
        issue_one(0, 1'b1, 16'($urandom), 1'b1);
        issue_one(0, 1'b0, 16'd0, 1'b0);
        end_test();

        start_test("back_pressure");
        for (i = 0; i < 40; i++) begin
            issue_one(int'($urandom_range(0, 3)), ($urandom_range(0, 7) == 0),
                      16'($urandom), ($urandom_range(0, 5) == 0));
        end
        end_test();

        start_test("bus_timeout");
        dead_en = 1'b1;
        issue_one(0, 1'b1, dead_addr, 1'b0);
        measure_cyc(len);
        if (len > int'(fetch_pkg::WB_TIMEOUT) + 2) begin
            report_rule($sformatf("bus cycle to a dead address lasted %0d cycles", len));
        end
        repeat (8) begin
            @(posedge CLK);
            #1;
            compare_word("bus_err_o", 16'd1, {15'd0, bus_err_o});
            compare_word("valid_o", 16'd0, {15'd0, valid_o});
        end
        // Final reset clears the error and the table
        RST = 1'b0;
        dead_en = 1'b0;
        exp_pc = fetch_pkg::RESET_PC;
        pred_tbl = '0;
        repeat (2) begin
            @(posedge CLK);
            #1;
        end
        compare_word("bus_err_o", 16'd0, {15'd0, bus_err_o});
        RST = 1'b1;
        issue_one(0, 1'b0, 16'd0, 1'b0);
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
    input  logic CLK,
    input  logic RST,
    // Wishbone classic master
    output logic wb_cyc_o,
    output logic wb_stb_o,
    output logic [fetch_pkg::XLEN-1:0] wb_adr_o,
    output logic wb_we_o,
    input  logic [fetch_pkg::XLEN-1:0] wb_dat_i,
    input  logic wb_ack_i,
    // Resolve from execute
    input  logic stall_i,
    input  logic jr_i,
    input  logic [fetch_pkg::XLEN-1:0] address_jr_i,
    input  logic prewrong_i,
    // Issue to decode
    output logic [fetch_pkg::XLEN-1:0] instr_o,
    output logic [fetch_pkg::XLEN-1:0] pc_o,
    output logic [fetch_pkg::XLEN-1:0] pcplus1_o,
    output logic pred_taken_o,
    output logic valid_o,
    output logic bus_err_o
);

    // Control strobes
    logic timer_run;
    logic timer_clr;
    logic timeout;
    logic pc_advance;
    logic instr_load;

    // Data path
    logic [fetch_pkg::XLEN-1:0] pc;
    logic [fetch_pkg::XLEN-1:0] instr;
    logic pred_bit;
    logic [fetch_pkg::PRED_IDX_W-1:0] lookup_idx;
    logic update;
    logic [fetch_pkg::PRED_IDX_W-1:0] update_idx;

    ////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////

    fetch_ctrl u_ctrl (
        .CLK          (CLK),
        .RST          (RST),
        .wb_ack_i     (wb_ack_i),
        .stall_i      (stall_i),
        .timeout_i    (timeout),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .valid_o      (valid_o),
        .instr_load_o (instr_load),
        .pc_advance_o (pc_advance),
        .timer_run_o  (timer_run),
        .timer_clr_o  (timer_clr),
        .bus_err_o    (bus_err_o)
    );

    wait_timer u_timer (
        .CLK       (CLK),
        .RST       (RST),
        .run_i     (timer_run),
        .clr_i     (timer_clr),
        .timeout_o (timeout)
    );

    ////////////////////////////////////////////////
    // Data path
    ////////////////////////////////////////////////

    branch_predictor u_pred (
        .CLK          (CLK),
        .RST          (RST),
        .lookup_idx_i (lookup_idx),
        .update_i     (update),
        .update_idx_i (update_idx),
        .pred_o       (pred_bit)
    );

    next_pc_unit u_npc (
        .CLK          (CLK),
        .RST          (RST),
        .instr_load_i (instr_load),
        .pc_advance_i (pc_advance),
        .wb_dat_i     (wb_dat_i),
        .pred_bit_i   (pred_bit),
        .jr_i         (jr_i),
        .address_jr_i (address_jr_i),
        .prewrong_i   (prewrong_i),
        .pc_o         (pc),
        .pcplus1_o    (pcplus1_o),
        .instr_o      (instr),
        .pred_taken_o (pred_taken_o),
        .lookup_idx_o (lookup_idx),
        .update_o     (update),
        .update_idx_o (update_idx)
    );

    // Read-only master, address is the fetch PC
    assign wb_adr_o = pc;
    assign wb_we_o = 1'b0;
    assign pc_o = pc;
    assign instr_o = instr;

endmodule

// File: hdl/fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl (
    input  logic CLK,
    input  logic RST,
    input  logic wb_ack_i,
    input  logic stall_i,
    input  logic timeout_i,
    output logic wb_cyc_o,
    output logic wb_stb_o,
    output logic valid_o,
    output logic instr_load_o,
    output logic pc_advance_o,
    output logic timer_run_o,
    output logic timer_clr_o,
    output logic bus_err_o
);

    // Current and next FSM state
    logic [fetch_pkg::FSM_W-1:0] state_q;
    logic [fetch_pkg::FSM_W-1:0] state_d;

    // State decodes
    logic in_req;
    logic in_issue;
    logic in_error;

    // Handshake events
    logic accept;
    logic bus_done;

    ////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////

    // START holds for one cycle after reset release
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            state_q <= fetch_pkg::ST_START;
        end else begin
            state_q <= state_d;
        end
    end

    assign in_req = (state_q == fetch_pkg::ST_REQ);
    assign in_issue = (state_q == fetch_pkg::ST_ISSUE);
    assign in_error = (state_q == fetch_pkg::ST_ERROR);

    // Word arrives, ack wins over a late timeout
    assign bus_done = in_req && wb_ack_i;
    // Decode takes the word
    assign accept = in_issue && !stall_i;

    ////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::ST_START: begin
                state_d = fetch_pkg::ST_REQ;
            end
            fetch_pkg::ST_REQ: begin
                if (wb_ack_i) begin
                    state_d = fetch_pkg::ST_ISSUE;
                end else if (timeout_i) begin
                    // Abort the cycle, no retry
                    state_d = fetch_pkg::ST_ERROR;
                end
            end
            fetch_pkg::ST_ISSUE: begin
                // Held here under back-pressure
                if (!stall_i) begin
                    state_d = fetch_pkg::ST_REQ;
                end
            end
            fetch_pkg::ST_ERROR: begin
                // Only reset leaves this state
                state_d = fetch_pkg::ST_ERROR;
            end
            default: begin
                state_d = fetch_pkg::ST_START;
            end
        endcase
    end

    ////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////

    // Classic cycle, cyc and stb move together
    assign wb_cyc_o = in_req;
    assign wb_stb_o = in_req;

    // Latch strobe in the ack cycle
    assign instr_load_o = bus_done;
    // Issue valid from the cycle after ack
    assign valid_o = in_issue;
    // PC step on acceptance
    assign pc_advance_o = accept;

    // Watchdog counts only during a bus cycle
    assign timer_run_o = in_req;
    assign timer_clr_o = !in_req;

    // Sticky through the error state
    assign bus_err_o = in_error;

endmodule

// File: hdl/next_pc_unit.sv
`timescale 1ns/1ns

module next_pc_unit (
    input  logic CLK,
    input  logic RST,
    input  logic instr_load_i,
    input  logic pc_advance_i,
    input  logic [fetch_pkg::XLEN-1:0] wb_dat_i,
    input  logic pred_bit_i,
    input  logic jr_i,
    input  logic [fetch_pkg::XLEN-1:0] address_jr_i,
    input  logic prewrong_i,
    output logic [fetch_pkg::XLEN-1:0] pc_o,
    output logic [fetch_pkg::XLEN-1:0] pcplus1_o,
    output logic [fetch_pkg::XLEN-1:0] instr_o,
    output logic pred_taken_o,
    output logic [fetch_pkg::PRED_IDX_W-1:0] lookup_idx_o,
    output logic update_o,
    output logic [fetch_pkg::PRED_IDX_W-1:0] update_idx_o
);

    // Fetch PC, also the bus address
    logic [fetch_pkg::XLEN-1:0] pc_q;
    // PC the latched word came from
    logic [fetch_pkg::XLEN-1:0] pc_lock_q;
    // Word from the ack cycle
    fetch_pkg::instr_word_u instr_q;

    logic is_jump;
    logic is_branch;
    logic pred_taken;
    logic [fetch_pkg::XLEN-1:0] ext_imm;
    logic [fetch_pkg::XLEN-1:0] pcplus1;
    logic [fetch_pkg::XLEN-1:0] pcplusimm;
    logic [fetch_pkg::XLEN-1:0] pc_next;

    ////////////////////////////////////////////////
    // Latched copies
    ////////////////////////////////////////////////

    // Word and its PC captured together on ack
    always_ff @(posedge CLK) begin
        if (instr_load_i) begin
            instr_q <= wb_dat_i;
            pc_lock_q <= pc_q;
        end
    end

    // PC moves only when decode takes the word
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            pc_q <= fetch_pkg::RESET_PC;
        end else if (pc_advance_i) begin
            pc_q <= pc_next;
        end
    end

    ////////////////////////////////////////////////
    // Decode and target
    ////////////////////////////////////////////////

    assign is_jump = (instr_q.jmp.opcode == fetch_pkg::OPC_JUMP);
    assign is_branch = (instr_q.br.opcode == fetch_pkg::OPC_BRANCH);

    // imm11 for jumps, imm8 for every other format
    always_comb begin
        if (is_jump) begin
            ext_imm = {{(fetch_pkg::XLEN-11){instr_q.jmp.imm11[10]}}, instr_q.jmp.imm11};
        end else begin
            ext_imm = {{(fetch_pkg::XLEN-8){instr_q.br.imm8[7]}}, instr_q.br.imm8};
        end
    end

    assign pcplus1 = pc_q + fetch_pkg::PC_INC;
    assign pcplusimm = pcplus1 + ext_imm;

    // Jumps always taken, branches follow the table
    assign pred_taken = is_jump || (is_branch && pred_bit_i);

    ////////////////////////////////////////////////
    // Next PC select
    ////////////////////////////////////////////////

    always_comb begin
        if (jr_i) begin
            pc_next = address_jr_i;
        end else if (prewrong_i) begin
            // Mispredict, take the path not predicted
            pc_next = pred_taken ? pcplus1 : pcplusimm;
        end else begin
            pc_next = pred_taken ? pcplusimm : pcplus1;
        end
    end

    // Issue outputs
    assign pc_o = pc_q;
    assign pcplus1_o = pcplus1;
    assign instr_o = instr_q;
    assign pred_taken_o = pred_taken;

    // Predictor lookup and training
    assign lookup_idx_o = pc_q[fetch_pkg::PRED_IDX_W-1:0];
    assign update_o = pc_advance_i && prewrong_i;
    assign update_idx_o = pc_lock_q[fetch_pkg::PRED_IDX_W-1:0];

endmodule

// File: hdl/branch_predictor.sv
`timescale 1ns/1ns

module branch_predictor (
    input  logic CLK,
    input  logic RST,
    input  logic [fetch_pkg::PRED_IDX_W-1:0] lookup_idx_i,
    input  logic update_i,
    input  logic [fetch_pkg::PRED_IDX_W-1:0] update_idx_i,
    output logic pred_o
);

    // One bit per entry, 1 means taken
    logic [fetch_pkg::PRED_DEPTH-1:0] table_q;

    ////////////////////////////////////////////////
    // Table update
    ////////////////////////////////////////////////

    // Whole table starts not-taken
    // Entry flips on a reported mispredict
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            table_q <= '0;
        end else if (update_i) begin
            table_q[update_idx_i] <= !table_q[update_idx_i];
        end
    end

    ////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////

    // Combinational read at the fetch PC
    // Aliasing above the index bits is intended
    assign pred_o = table_q[lookup_idx_i];

endmodule

// File: hdl/wait_timer.sv
`timescale 1ns/1ns

module wait_timer (
    input  logic CLK,
    input  logic RST,
    input  logic run_i,
    input  logic clr_i,
    output logic timeout_o
);

    // Wait cycles seen in the current bus cycle
    logic [fetch_pkg::TIMER_W-1:0] count_q;
    logic at_limit;

    ////////////////////////////////////////////////
    // Saturating wait counter
    ////////////////////////////////////////////////

    assign at_limit = (count_q == fetch_pkg::WB_TIMEOUT);

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            count_q <= '0;
        end else if (clr_i) begin
            // New bus cycle starts from zero
            count_q <= '0;
        end else if (run_i && !at_limit) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Held high once the limit is reached
    assign timeout_o = at_limit;

endmodule

// File: hdl/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////////////
    // Data path sizes
    ////////////////////////////////////////////////

    // Data and word address width
    localparam int XLEN = 16;
    // Predictor table, indexed by low PC bits
    localparam int PRED_IDX_W = 8;
    localparam int PRED_DEPTH = 256;

    // PC after reset and sequential step
    localparam logic [XLEN-1:0] RESET_PC = '0;
    localparam logic [XLEN-1:0] PC_INC = 1;

    // Opcodes in instr[15:11]
    localparam logic [4:0] OPC_JUMP = 5'b00010;
    localparam logic [4:0] OPC_BRANCH = 5'b00011;

    // Wait-state watchdog
    localparam int TIMER_W = 5;
    localparam logic [TIMER_W-1:0] WB_TIMEOUT = 5'd16;

    // Fetch FSM encoding
    localparam int FSM_W = 2;
    localparam logic [FSM_W-1:0] ST_START = 2'd0;
    localparam logic [FSM_W-1:0] ST_REQ = 2'd1;
    localparam logic [FSM_W-1:0] ST_ISSUE = 2'd2;
    localparam logic [FSM_W-1:0] ST_ERROR = 2'd3;

    ////////////////////////////////////////////////
    // Instruction word, two decodings of one word
    ////////////////////////////////////////////////

    // Jump format, long immediate
    typedef struct packed {
        logic [4:0] opcode;
        logic [10:0] imm11;
    } jump_fmt_t;

    // Branch format, register select unused by fetch
    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rsel;
        logic [7:0] imm8;
    } branch_fmt_t;

    typedef union packed {
        jump_fmt_t jmp;
        branch_fmt_t br;
    } instr_word_u;

endpackage
